//--- src/kpu_isa_pkg.sv
package kpu_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [15:0] imm_t;
  typedef logic [7:0]  mem_addr_t;

  // Register form of the opcode word
  typedef struct packed {
    logic [10:0] spare;
    reg_idx_t    src2;
    reg_idx_t    src1;
    reg_idx_t    src0;
    opcode_t     opcode;
  } opword_reg_t;

  // Immediate form, imm sits on top of src2
  typedef struct packed {
    imm_t     imm;
    reg_idx_t src1;
    reg_idx_t src0;
    opcode_t  opcode;
  } opword_imm_t;

  typedef union packed {
    opword_reg_t r;
    opword_imm_t i;
  } opword_t;

  // Zero decodes as HALT, as does anything not listed
  localparam opcode_t OP_HALT = 6'd0;
  localparam opcode_t OP_LDI  = 6'd1;
  localparam opcode_t OP_ADD  = 6'd2;
  localparam opcode_t OP_SUB  = 6'd3;
  localparam opcode_t OP_AND  = 6'd4;
  localparam opcode_t OP_OR   = 6'd5;
  localparam opcode_t OP_XOR  = 6'd6;
  localparam opcode_t OP_SHL  = 6'd7;
  localparam opcode_t OP_SHR  = 6'd8;
  localparam opcode_t OP_SRA  = 6'd9;
  localparam opcode_t OP_LD   = 6'd10;
  localparam opcode_t OP_ST   = 6'd11;
  localparam opcode_t OP_JZ   = 6'd12;
  localparam opcode_t OP_OUT  = 6'd13;
  localparam opcode_t OP_TIME = 6'd14;

  localparam int NUM_REGS    = 32;
  localparam int PC_REG      = 31;
  localparam int MEM_DEPTH   = 256;
  localparam int OUT_CREDITS = 2;
  localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1);

  typedef logic [CREDIT_W-1:0] credit_t;

endpackage

//--- src/kpu_ctrl_pkg.sv
package kpu_ctrl_pkg;

  // Which unit owns the shared bus this cycle
  typedef enum logic [3:0] {
    BUS_NONE,
    BUS_REG,
    BUS_TMP0,
    BUS_TMP1,
    BUS_MLU,
    BUS_TIMER,
    BUS_MEM,
    BUS_CTRL_DATA,
    BUS_IMM
  } bus_src_e;

  typedef enum logic [1:0] {
    SEL_SRC0,
    SEL_SRC1,
    SEL_SRC2,
    SEL_PC
  } reg_sel_e;

  typedef enum logic [2:0] {
    MLU_ADD,
    MLU_SUB,
    MLU_AND,
    MLU_OR,
    MLU_XOR,
    MLU_SHL,
    MLU_SHR,
    MLU_SRA
  } mlu_op_e;

  // One microstep, all-zero is a bus idle cycle
  typedef struct packed {
    bus_src_e   bus_src;
    reg_sel_e   reg_sel;
    logic       reg_we;
    logic       tmp0_we;
    logic       tmp1_we;
    logic       mem_we;
    logic       opword_we;
    logic       out_push;
    mlu_op_e    mlu_op;
    logic [7:0] ctrl_data;
  } ctrl_word_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_FETCH,
    SEQ_EXEC,
    SEQ_HALTED
  } seq_state_e;

  typedef logic [1:0] ustep_t;

endpackage

//--- src/mlu.sv
module mlu
  import kpu_isa_pkg::*;
  import kpu_ctrl_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  mlu_op_e op,
  output word_t   result,
  output logic    zero,
  output logic    carry,
  output logic    negative
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    result = '0;
    carry  = 1'b0;
    case (op)
      MLU_ADD: {carry, result} = {1'b0, a} + {1'b0, b};
      // Carry is the borrow out on subtract
      MLU_SUB: {carry, result} = {1'b0, a} - {1'b0, b};
      MLU_AND: result = a & b;
      MLU_OR:  result = a | b;
      MLU_XOR: result = a ^ b;
      MLU_SHL: result = a << shamt;
      MLU_SHR: result = a >> shamt;
      MLU_SRA: result = word_t'($signed(a) >>> shamt);
      default: result = '0;
    endcase
  end

  assign zero     = (result == '0);
  assign negative = result[$bits(word_t)-1];

endmodule

//--- src/register_file.sv
module register_file
  import kpu_isa_pkg::*;
  import kpu_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  ctrl_word_t ctrl,
  input  reg_idx_t   src0,
  input  reg_idx_t   src1,
  input  reg_idx_t   src2,
  input  word_t      bus,
  output word_t      reg_rdata
);

  reg_idx_t idx;
  word_t    regs [NUM_REGS];

  always_comb begin
    case (ctrl.reg_sel)
      SEL_SRC0: idx = src0;
      SEL_SRC1: idx = src1;
      SEL_SRC2: idx = src2;
      default:  idx = reg_idx_t'(PC_REG);
    endcase
  end

  // r0 is hardwired to zero
  assign reg_rdata = (idx == '0) ? '0 : regs[idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.reg_we && idx != '0) begin
      regs[idx] <= bus;
    end
  end

endmodule

//--- src/mmu.sv
module mmu
  import kpu_isa_pkg::*;
  import kpu_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       run,
  input  ctrl_word_t ctrl,
  input  mem_addr_t  addr,
  input  word_t      bus,
  input  logic       prog_we,
  input  mem_addr_t  prog_addr,
  input  word_t      prog_data,
  output word_t      mem_rdata
);

  word_t mem [MEM_DEPTH];

  assign mem_rdata = mem[addr];

  // Core owns the write port while running, the loader otherwise
  always_ff @(posedge clk) begin
    if (run) begin
      if (ctrl.mem_we) begin
        mem[addr] <= bus;
      end
    end else if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

endmodule

//--- src/out_port.sv
module out_port
  import kpu_isa_pkg::*;
  import kpu_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  ctrl_word_t ctrl,
  input  word_t      bus,
  input  logic       out_credit,
  output logic       credit_avail,
  output word_t      out_data,
  output logic       out_valid
);

  credit_t credit_cnt;

  assign credit_avail = (credit_cnt != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt <= credit_t'(OUT_CREDITS);
      out_valid  <= 1'b0;
    end else begin
      out_valid <= ctrl.out_push;
      // Push and return together cancel out
      case ({ctrl.out_push, out_credit})
        2'b10: credit_cnt <= credit_cnt - credit_t'(1);
        2'b01: begin
          if (credit_cnt != credit_t'(OUT_CREDITS)) begin
            credit_cnt <= credit_cnt + credit_t'(1);
          end
        end
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.out_push) begin
      out_data <= bus;
    end
  end

endmodule

//--- src/bus_hub.sv
module bus_hub
  import kpu_isa_pkg::*;
  import kpu_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  ctrl_word_t ctrl,
  input  word_t      reg_rdata,
  input  word_t      mlu_result,
  input  word_t      mem_rdata,
  input  word_t      timer,
  output word_t      bus,
  output word_t      tmp0,
  output word_t      tmp1,
  output opcode_t    opcode,
  output reg_idx_t   src0,
  output reg_idx_t   src1,
  output reg_idx_t   src2
);

  opword_t opword;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tmp0   <= '0;
      tmp1   <= '0;
      opword <= '0;
    end else begin
      if (ctrl.tmp0_we) begin
        tmp0 <= bus;
      end
      if (ctrl.tmp1_we) begin
        tmp1 <= bus;
      end
      if (ctrl.opword_we) begin
        opword <= bus;
      end
    end
  end

  assign opcode = opword.r.opcode;
  assign src0   = opword.r.src0;
  assign src1   = opword.r.src1;
  assign src2   = opword.r.src2;

  // Single bus driver, immediate and ctrl_data zero-extended
  always_comb begin
    case (ctrl.bus_src)
      BUS_REG:       bus = reg_rdata;
      BUS_TMP0:      bus = tmp0;
      BUS_TMP1:      bus = tmp1;
      BUS_MLU:       bus = mlu_result;
      BUS_TIMER:     bus = timer;
      BUS_MEM:       bus = mem_rdata;
      BUS_CTRL_DATA: bus = word_t'(ctrl.ctrl_data);
      BUS_IMM:       bus = word_t'(opword.i.imm);
      default:       bus = '0;
    endcase
  end

endmodule

//--- src/control_logic.sv
module control_logic
  import kpu_isa_pkg::*;
  import kpu_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       run,
  input  opcode_t    opcode,
  input  logic       mlu_zero,
  input  logic       credit_avail,
  output ctrl_word_t ctrl,
  output word_t      timer,
  output logic       halted
);

  seq_state_e state;
  ustep_t     step;
  logic       out_stall;
  logic       stop;

  // Fetch: pc to tmp0, mem to opword, 1 to tmp1, pc+1 back to pc
  function automatic ctrl_word_t fetch_uop(ustep_t s);
    ctrl_word_t cw;
    cw = '0;
    case (s)
      2'd0: begin
        cw.bus_src = BUS_REG;
        cw.reg_sel = SEL_PC;
        cw.tmp0_we = 1'b1;
      end
      2'd1: begin
        cw.bus_src   = BUS_MEM;
        cw.opword_we = 1'b1;
      end
      2'd2: begin
        cw.bus_src   = BUS_CTRL_DATA;
        cw.ctrl_data = 8'd1;
        cw.tmp1_we   = 1'b1;
      end
      default: begin
        cw.bus_src = BUS_MLU;
        cw.mlu_op  = MLU_ADD;
        cw.reg_sel = SEL_PC;
        cw.reg_we  = 1'b1;
      end
    endcase
    return cw;
  endfunction

  function automatic mlu_op_e alu_op(opcode_t op);
    case (op)
      OP_SUB:  return MLU_SUB;
      OP_AND:  return MLU_AND;
      OP_OR:   return MLU_OR;
      OP_XOR:  return MLU_XOR;
      OP_SHL:  return MLU_SHL;
      OP_SHR:  return MLU_SHR;
      OP_SRA:  return MLU_SRA;
      default: return MLU_ADD;
    endcase
  endfunction

  // Execute table, indexed by opcode and microstep
  function automatic ctrl_word_t exec_uop(opcode_t op, ustep_t s);
    ctrl_word_t cw;
    cw = '0;
    case (op)
      OP_LDI: begin
        cw.bus_src = BUS_IMM;
        cw.reg_we  = 1'b1;
      end
      OP_TIME: begin
        cw.bus_src = BUS_TIMER;
        cw.reg_we  = 1'b1;
      end
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_SRA: begin
        cw.bus_src = (s == 2'd2) ? BUS_MLU : BUS_REG;
        cw.reg_sel = (s == 2'd0) ? SEL_SRC1 : (s == 2'd1) ? SEL_SRC2 : SEL_SRC0;
        cw.tmp0_we = (s == 2'd0);
        cw.tmp1_we = (s == 2'd1);
        cw.reg_we  = (s == 2'd2);
        cw.mlu_op  = alu_op(op);
      end
      OP_LD, OP_ST: begin
        cw.bus_src = (s == 2'd1 && op == OP_LD) ? BUS_MEM : BUS_REG;
        cw.reg_sel = (s == 2'd0) ? SEL_SRC1 : SEL_SRC0;
        cw.tmp0_we = (s == 2'd0);
        cw.reg_we  = (s == 2'd1) && (op == OP_LD);
        cw.mem_we  = (s == 2'd1) && (op == OP_ST);
      end
      OP_JZ: begin
        // Last step writes pc only when the condition holds
        cw.bus_src = (s == 2'd0) ? BUS_REG : (s == 2'd1) ? BUS_CTRL_DATA : BUS_IMM;
        cw.reg_sel = (s == 2'd0) ? SEL_SRC0 : SEL_PC;
        cw.tmp0_we = (s == 2'd0);
        cw.tmp1_we = (s == 2'd1);
        cw.mlu_op  = MLU_OR;
      end
      OP_OUT: begin
        cw.bus_src  = BUS_REG;
        cw.out_push = 1'b1;
      end
      default: cw = '0;
    endcase
    return cw;
  endfunction

  function automatic ustep_t last_step(opcode_t op);
    case (op)
      OP_LD, OP_ST: return 2'd1;
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_SRA, OP_JZ: return 2'd2;
      default: return 2'd0;
    endcase
  endfunction

  function automatic logic is_stop(opcode_t op);
    return (op == OP_HALT) || (op > OP_TIME);
  endfunction

  assign out_stall = (opcode == OP_OUT) && !credit_avail;
  assign stop      = is_stop(opcode);
  assign halted    = (state == SEQ_HALTED);

  always_comb begin
    ctrl = '0;
    case (state)
      SEQ_FETCH: ctrl = fetch_uop(step);
      SEQ_EXEC: begin
        ctrl = exec_uop(opcode, step);
        if (opcode == OP_JZ && step == 2'd2) begin
          ctrl.reg_we = mlu_zero;
        end
        if (opcode == OP_OUT) begin
          ctrl.out_push = credit_avail;
        end
      end
      default: ctrl = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= SEQ_IDLE;
      step  <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (run) begin
            state <= SEQ_FETCH;
            step  <= '0;
          end
        end
        SEQ_FETCH: begin
          if (step == 2'd3) begin
            state <= SEQ_EXEC;
            step  <= '0;
          end else begin
            step <= step + ustep_t'(1);
          end
        end
        SEQ_EXEC: begin
          if (stop) begin
            state <= SEQ_HALTED;
          end else if (!out_stall) begin
            if (step == last_step(opcode)) begin
              state <= SEQ_FETCH;
              step  <= '0;
            end else begin
              step <= step + ustep_t'(1);
            end
          end
        end
        default: state <= SEQ_HALTED;
      endcase
    end
  end

  // Cycle counter, free running from reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timer <= '0;
    end else begin
      timer <= timer + word_t'(1);
    end
  end

endmodule

//--- src/kpu_core.sv
module kpu_core
  import kpu_isa_pkg::*;
  import kpu_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      run,
  input  logic      prog_we,
  input  mem_addr_t prog_addr,
  input  word_t     prog_data,
  input  logic      out_credit,
  output word_t     out_data,
  output logic      out_valid,
  output logic      halted
);

  word_t      bus;
  ctrl_word_t ctrl;
  word_t      timer;
  word_t      tmp0;
  word_t      tmp1;
  opcode_t    opcode;
  reg_idx_t   src0;
  reg_idx_t   src1;
  reg_idx_t   src2;
  word_t      reg_rdata;
  word_t      mlu_result;
  logic       mlu_zero;
  word_t      mem_rdata;
  logic       credit_avail;

  control_logic u_control (
    .clk          (clk),
    .rst_n        (rst_n),
    .run          (run),
    .opcode       (opcode),
    .mlu_zero     (mlu_zero),
    .credit_avail (credit_avail),
    .ctrl         (ctrl),
    .timer        (timer),
    .halted       (halted)
  );

  bus_hub u_bus_hub (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .reg_rdata  (reg_rdata),
    .mlu_result (mlu_result),
    .mem_rdata  (mem_rdata),
    .timer      (timer),
    .bus        (bus),
    .tmp0       (tmp0),
    .tmp1       (tmp1),
    .opcode     (opcode),
    .src0       (src0),
    .src1       (src1),
    .src2       (src2)
  );

  register_file u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .src0      (src0),
    .src1      (src1),
    .src2      (src2),
    .bus       (bus),
    .reg_rdata (reg_rdata)
  );

  // Carry and negative have no consumer in this ISA
  mlu u_mlu (
    .a        (tmp0),
    .b        (tmp1),
    .op       (ctrl.mlu_op),
    .result   (mlu_result),
    .zero     (mlu_zero),
    .carry    (),
    .negative ()
  );

  mmu u_mmu (
    .clk       (clk),
    .run       (run),
    .ctrl      (ctrl),
    .addr      (tmp0[$bits(mem_addr_t)-1:0]),
    .bus       (bus),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .mem_rdata (mem_rdata)
  );

  out_port u_out_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl         (ctrl),
    .bus          (bus),
    .out_credit   (out_credit),
    .credit_avail (credit_avail),
    .out_data     (out_data),
    .out_valid    (out_valid)
  );

endmodule

//--- verif/kpu_props.sv
module kpu_props
  import kpu_isa_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input credit_t credit_cnt,
  input logic    out_valid,
  input logic    halted
);

  // Counter never climbs past its reset value
  credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= credit_t'(OUT_CREDITS))
    else $error("credit count above OUT_CREDITS");

  valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(out_valid) |-> $past(credit_cnt) != '0)
    else $error("out_valid rose with no credit available");

  halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted)
    else $error("halted dropped before reset");

endmodule

bind out_port kpu_props i_credit_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .credit_cnt (credit_cnt),
  .out_valid  (out_valid),
  .halted     (1'b0)
);

bind control_logic kpu_props i_halt_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .credit_cnt ('0),
  .out_valid  (1'b0),
  .halted     (halted)
);

//--- verif/kpu_tb.sv
module kpu_tb
  import kpu_isa_pkg::*;
();

  localparam int LOOP_N          = 5;
  localparam int WITHHOLD_AFTER  = 4;
  localparam int WITHHOLD_CYCLES = 40;

  logic      clk;
  logic      rst_n;
  logic      run;
  logic      prog_we;
  mem_addr_t prog_addr;
  word_t     prog_data;
  logic      out_credit;
  word_t     out_data;
  logic      out_valid;
  logic      halted;

  word_t program_mem [MEM_DEPTH];
  int    prog_len;
  word_t expected_q [$];
  string name_q [$];
  int    sec_start [8];
  string sec_name [8];
  int    n_sec;
  int    errors = 0;
  int    out_count = 0;
  int    returned = 0;
  int    window_outs = 0;
  logic  withholding = 1'b0;
  logic  withheld_done = 1'b0;
  int    seed = 43;
  int    cycles = 0;

  kpu_core i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .out_credit (out_credit),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .halted     (halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check(string name, word_t expected, word_t actual);
    if (expected !== actual) begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // Register form: src2, src1, dest, opcode from the top down
  function automatic word_t enc_r(opcode_t op, reg_idx_t d, reg_idx_t s1, reg_idx_t s2);
    return {11'b0, s2, s1, d, op};
  endfunction

  function automatic word_t enc_i(opcode_t op, reg_idx_t d, imm_t imm);
    return {imm, 5'b0, d, op};
  endfunction

  task automatic emit(word_t w);
    program_mem[prog_len] = w;
    prog_len++;
  endtask

  task automatic start_section(string name);
    sec_start[n_sec] = prog_len;
    sec_name[n_sec]  = name;
    n_sec++;
  endtask

  function automatic string section_of(int addr);
    string name;
    name = "none";
    for (int i = 0; i < n_sec; i++) begin
      if (addr >= sec_start[i]) begin
        name = sec_name[i];
      end
    end
    return name;
  endfunction

  task automatic build_program();
    int loop_top;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      program_mem[i] = '0;
    end
    prog_len = 0;
    n_sec    = 0;
    start_section("alu");
    emit(enc_i(OP_LDI, 5'd1, 16'h1234));
    emit(enc_i(OP_LDI, 5'd2, 16'h0f0f));
    emit(enc_r(OP_ADD, 5'd3, 5'd1, 5'd2));
    emit(enc_r(OP_OUT, 5'd3, 5'd0, 5'd0));
    emit(enc_r(OP_SUB, 5'd3, 5'd2, 5'd1));
    emit(enc_r(OP_OUT, 5'd3, 5'd0, 5'd0));
    emit(enc_r(OP_AND, 5'd3, 5'd1, 5'd2));
    emit(enc_r(OP_OUT, 5'd3, 5'd0, 5'd0));
    emit(enc_r(OP_OR, 5'd3, 5'd1, 5'd2));
    emit(enc_r(OP_OUT, 5'd3, 5'd0, 5'd0));
    emit(enc_r(OP_XOR, 5'd3, 5'd1, 5'd2));
    emit(enc_r(OP_OUT, 5'd3, 5'd0, 5'd0));
    // All ones from 0 - 1, then an add that wraps
    emit(enc_i(OP_LDI, 5'd4, 16'd1));
    emit(enc_r(OP_SUB, 5'd5, 5'd0, 5'd4));
    emit(enc_r(OP_ADD, 5'd6, 5'd5, 5'd2));
    emit(enc_r(OP_OUT, 5'd6, 5'd0, 5'd0));
    start_section("shift");
    emit(enc_r(OP_XOR, 5'd7, 5'd5, 5'd1));
    emit(enc_i(OP_LDI, 5'd8, 16'd31));
    emit(enc_r(OP_SHL, 5'd9, 5'd7, 5'd4));
    emit(enc_r(OP_OUT, 5'd9, 5'd0, 5'd0));
    emit(enc_r(OP_SHL, 5'd9, 5'd7, 5'd8));
    emit(enc_r(OP_OUT, 5'd9, 5'd0, 5'd0));
    emit(enc_r(OP_SHL, 5'd9, 5'd7, 5'd0));
    emit(enc_r(OP_OUT, 5'd9, 5'd0, 5'd0));
    emit(enc_r(OP_SHR, 5'd9, 5'd7, 5'd4));
    emit(enc_r(OP_OUT, 5'd9, 5'd0, 5'd0));
    emit(enc_r(OP_SRA, 5'd9, 5'd7, 5'd4));
    emit(enc_r(OP_OUT, 5'd9, 5'd0, 5'd0));
    emit(enc_r(OP_SHR, 5'd9, 5'd7, 5'd8));
    emit(enc_r(OP_OUT, 5'd9, 5'd0, 5'd0));
    emit(enc_r(OP_SRA, 5'd9, 5'd7, 5'd8));
    emit(enc_r(OP_OUT, 5'd9, 5'd0, 5'd0));
    emit(enc_r(OP_SHR, 5'd9, 5'd7, 5'd0));
    emit(enc_r(OP_OUT, 5'd9, 5'd0, 5'd0));
    emit(enc_r(OP_SRA, 5'd9, 5'd7, 5'd0));
    emit(enc_r(OP_OUT, 5'd9, 5'd0, 5'd0));
    start_section("mem");
    emit(enc_i(OP_LDI, 5'd10, 16'd200));
    emit(enc_r(OP_ST, 5'd7, 5'd10, 5'd0));
    emit(enc_r(OP_LD, 5'd11, 5'd10, 5'd0));
    emit(enc_r(OP_OUT, 5'd11, 5'd0, 5'd0));
    start_section("loop");
    emit(enc_i(OP_LDI, 5'd12, imm_t'(LOOP_N)));
    loop_top = prog_len;
    emit(enc_r(OP_OUT, 5'd12, 5'd0, 5'd0));
    emit(enc_r(OP_SUB, 5'd12, 5'd12, 5'd4));
    emit(enc_i(OP_JZ, 5'd12, imm_t'(loop_top + 4)));
    emit(enc_i(OP_JZ, 5'd0, imm_t'(loop_top)));
    start_section("time");
    emit(enc_r(OP_TIME, 5'd14, 5'd0, 5'd0));
    emit(enc_r(OP_TIME, 5'd15, 5'd0, 5'd0));
    emit(enc_r(OP_SUB, 5'd16, 5'd15, 5'd14));
    emit(enc_r(OP_OUT, 5'd16, 5'd0, 5'd0));
    emit(enc_r(OP_HALT, 5'd0, 5'd0, 5'd0));
  endtask

  // Execute length in cycles, fetch adds four more
  function automatic int exec_cycles(opcode_t op);
    case (op)
      OP_LDI, OP_TIME, OP_OUT: return 1;
      OP_LD, OP_ST: return 2;
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_SRA, OP_JZ: return 3;
      default: return 0;
    endcase
  endfunction

  // Instruction-level interpreter, cycle count only feeds TIME
  function automatic void kpu_model();
    word_t    regs [32];
    word_t    mem [MEM_DEPTH];
    word_t    ir;
    word_t    a;
    word_t    b;
    word_t    res;
    logic     wr;
    logic     done;
    opcode_t  op;
    reg_idx_t d;
    int       at;
    int       cycle;
    int       guard;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < MEM_DEPTH; i++) begin
      mem[i] = program_mem[i];
    end
    cycle = 0;
    guard = 0;
    done  = 1'b0;
    while (!done && guard < 2000) begin
      at             = int'(regs[PC_REG][7:0]);
      ir             = mem[at];
      regs[PC_REG]   = regs[PC_REG] + 32'd1;
      cycle         += 4;
      op             = ir[5:0];
      d              = ir[10:6];
      a              = regs[ir[15:11]];
      b              = regs[ir[20:16]];
      wr             = 1'b1;
      res            = '0;
      case (op)
        OP_LDI:  res = {16'h0, ir[31:16]};
        OP_TIME: res = word_t'(cycle);
        OP_ADD:  res = a + b;
        OP_SUB:  res = a - b;
        OP_AND:  res = a & b;
        OP_OR:   res = a | b;
        OP_XOR:  res = a ^ b;
        OP_SHL:  res = a << b[4:0];
        OP_SHR:  res = a >> b[4:0];
        OP_SRA:  res = (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
        OP_LD:   res = mem[a[7:0]];
        OP_ST: begin
          mem[a[7:0]] = regs[d];
          wr          = 1'b0;
        end
        OP_JZ: begin
          if (regs[d] == '0) begin
            regs[PC_REG] = {16'h0, ir[31:16]};
          end
          wr = 1'b0;
        end
        OP_OUT: begin
          expected_q.push_back(regs[d]);
          name_q.push_back(section_of(at));
          wr = 1'b0;
        end
        default: begin
          wr   = 1'b0;
          done = 1'b1;
        end
      endcase
      cycle += exec_cycles(op);
      if (wr && d != '0) begin
        regs[d] = res;
      end
      guard++;
    end
    if (!done) begin
      $display("reference model never reached HALT");
      errors++;
    end
  endfunction

  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      @(negedge clk);
      prog_we   = 1'b1;
      prog_addr = mem_addr_t'(i);
      prog_data = program_mem[i];
    end
    @(negedge clk);
    prog_we = 1'b0;
  endtask

  // Outputs are sampled on the edge that follows the registered pulse
  always @(posedge clk) begin
    if (out_valid) begin
      if (halted) begin
        $display("output %h appeared after halted was raised", out_data);
        errors++;
      end
      if (expected_q.size() == 0) begin
        $display("output %h appeared with no expected value left", out_data);
        errors++;
      end else begin
        check($sformatf("%s out %0d", name_q.pop_front(), out_count),
              expected_q.pop_front(), out_data);
      end
      out_count++;
      if (withholding) begin
        window_outs++;
      end
    end
  end

  // One credit back per output, with one long withheld stretch
  initial begin : credit_return
    int delay;
    out_credit = 1'b0;
    forever begin
      @(negedge clk);
      out_credit = 1'b0;
      if (returned == WITHHOLD_AFTER && !withheld_done) begin
        withholding = 1'b1;
        repeat (WITHHOLD_CYCLES) @(negedge clk);
        withholding   = 1'b0;
        withheld_done = 1'b1;
      end else if (returned < out_count) begin
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clk);
        out_credit = 1'b1;
        returned++;
      end
    end
  end

  initial begin
    int limit;
    rst_n     = 1'b0;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    build_program();
    kpu_model();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    load_program();
    @(negedge clk);
    run   = 1'b1;
    limit = prog_len * 7 + LOOP_N * 4 * 7 + WITHHOLD_CYCLES + 200;
    while (!halted && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("timeout: core did not halt within %0d cycles", limit);
      errors++;
    end
    // Quiet window to catch any output after halt
    repeat (20) @(negedge clk);
    if (expected_q.size() != 0) begin
      $display("%0d expected outputs never appeared", expected_q.size());
      errors++;
    end
    if (!withheld_done) begin
      $display("credit withholding phase never ran");
      errors++;
    end
    if (window_outs > OUT_CREDITS) begin
      $display("%0d outputs appeared while credits were withheld", window_outs);
      errors++;
    end
    $display("outputs compared: %0d, errors: %0d", out_count, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
src/kpu_isa_pkg.sv
src/kpu_ctrl_pkg.sv
src/mlu.sv
src/register_file.sv
src/mmu.sv
src/out_port.sv
src/bus_hub.sv
src/control_logic.sv
src/kpu_core.sv
verif/kpu_props.sv
verif/kpu_tb.sv

//--- Bender.yml
package:
  name: kpu

sources:
  - files:
      - src/kpu_isa_pkg.sv
      - src/kpu_ctrl_pkg.sv
      - src/mlu.sv
      - src/register_file.sv
      - src/mmu.sv
      - src/out_port.sv
      - src/bus_hub.sv
      - src/control_logic.sv
      - src/kpu_core.sv
  - target: test
    files:
      - verif/kpu_props.sv
      - verif/kpu_tb.sv
